// File: compile.f
+incdir+hw
hw/i2c_pkg.sv
hw/adc_pkg.sv
hw/i2c_master.sv
hw/adc_sequencer.sv
hw/channel_averager.sv
hw/result_publisher.sv
hw/adc_scan_top.sv
tests/tla2024_model.sv
tests/adc_scan_asserts.sv
tests/tb_adc_scan.sv

// File: hw/adc_pkg.sv
`default_nettype none

package adc_pkg;

	// configuration register, msb first.
	// mux 4+n selects single-ended channel n.
	typedef struct packed {
		logic			os;
		logic [2:0]		mux;
		logic [2:0]		pga;
		logic			mode;
		logic [2:0]		dr;
		logic [4:0]		rsvd;
	} adc_cfg_reg_t;

	// conversion register, 12-bit code left aligned.
	typedef struct packed {
		logic [11:0]	code;
		logic [3:0]		unused;
	} adc_conv_reg_t;

	// the same read word, seen as whichever register the pointer selects.
	typedef union packed {
		adc_cfg_reg_t	cfg;
		adc_conv_reg_t	conv;
	} adc_word_u;

	typedef struct packed {
		logic [1:0]		ch;
		logic [11:0]	code;
	} adc_sample_t;

	// channel 0 in the low bits.
	typedef logic [3:0][11:0] adc_results_t;

endpackage

`default_nettype wire

// File: hw/adc_scan_cfg.svh
`ifndef ADC_SCAN_CFG_SVH
`define ADC_SCAN_CFG_SVH

// 7-bit slave address of the adc.
`define ADC_I2C_ADDR		7'h48
// clk cycles per quarter of an scl period.
`define I2C_QUARTER_CLKS	4
// each mean covers 2**ADC_AVG_LOG2 samples.
`define ADC_AVG_LOG2		5
`define ADC_NUM_CH			4
// gain and data rate, written with every channel select.
`define ADC_PGA_BITS		3'b001
`define ADC_DR_BITS			3'b110

`endif

// File: hw/adc_scan_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_scan_cfg.svh"

module adc_scan_top (
	input	wire					clk,
	input	wire					rst_n,
	output	logic					o_scl,
	inout	wire					io_sda,
	output	adc_pkg::adc_results_t	o_results,
	output	logic					o_valid,
	output	logic					o_error
);
	import i2c_pkg::*;
	import adc_pkg::*;

	i2c_req_t				req;
	logic					start;
	logic					i2c_end;
	logic					i2c_err;
	adc_word_u				rdata;
	adc_sample_t			sample;
	logic					sample_stb;
	logic [`ADC_NUM_CH-1:0]	ch_stb;
	logic [`ADC_NUM_CH-1:0]	mean_stb;
	adc_results_t			means;

	assign o_error = i2c_end & i2c_err;

	i2c_master u_master (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_req		(req),
		.i_start	(start),
		.o_end		(i2c_end),
		.o_error	(i2c_err),
		.o_rdata	(rdata),
		.o_scl		(o_scl),
		.io_sda		(io_sda)
	);

	adc_sequencer u_seq (
		.clk			(clk),
		.rst_n			(rst_n),
		.o_req			(req),
		.o_start		(start),
		.i_end			(i2c_end),
		.i_error		(i2c_err),
		.i_rdata		(rdata),
		.o_sample		(sample),
		.o_sample_stb	(sample_stb)
	);

	// one averager per channel, fed by the decoded sample strobe.
	for (genvar g = 0; g < `ADC_NUM_CH; g++) begin : g_avg
		assign ch_stb[g] = sample_stb && (sample.ch == 2'(g));

		channel_averager u_avg (
			.clk			(clk),
			.rst_n			(rst_n),
			.i_sample_stb	(ch_stb[g]),
			.i_code			(sample.code),
			.o_mean_stb		(mean_stb[g]),
			.o_mean			(means[g])
		);
	end

	result_publisher u_pub (
		.clk			(clk),
		.rst_n			(rst_n),
		.i_mean_stb		(mean_stb),
		.i_means		(means),
		.o_results		(o_results),
		.o_valid		(o_valid)
	);

endmodule

`default_nettype wire

// File: hw/adc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_scan_cfg.svh"

module adc_sequencer (
	input	wire					clk,
	input	wire					rst_n,
	output	i2c_pkg::i2c_req_t		o_req,
	output	logic					o_start,
	input	wire					i_end,
	input	wire					i_error,
	input	wire adc_pkg::adc_word_u	i_rdata,
	output	adc_pkg::adc_sample_t	o_sample,
	output	logic					o_sample_stb
);
	import i2c_pkg::*;
	import adc_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_KICK, S_WAIT} state_e;

	state_e						r_state;
	i2c_req_t					r_req;
	logic [1:0]					r_ch;
	logic [1:0]					next_ch;
	logic [`ADC_AVG_LOG2-1:0]	r_count;
	logic						last_sample;
	logic						conv_ok;
	i2c_req_t					next_req;

	// single-shot conversion on channel ch.
	function automatic i2c_req_t cfg_request(input logic [1:0] ch);
		adc_cfg_reg_t	cfg;
		i2c_req_t		req;
		cfg.os = 1'b1;
		cfg.mux = {1'b1, ch};
		cfg.pga = `ADC_PGA_BITS;
		cfg.mode = 1'b1;
		cfg.dr = `ADC_DR_BITS;
		cfg.rsvd = 5'd0;
		req.cmd = SET_CFG;
		req.wdata = cfg;
		return req;
	endfunction

	assign o_req = r_req;
	assign conv_ok = i_end && !i_error && (r_req.cmd == GET_CONV);
	assign last_sample = (r_count == '1);
	assign next_ch = (r_ch == 2'(`ADC_NUM_CH - 1)) ? 2'd0 : r_ch + 2'd1;

	// next transaction, chosen from the one that just ended.
	always_comb begin
		next_req = r_req;
		if (i_error)
			next_req = cfg_request(r_ch);
		else begin
			case (r_req.cmd)
				SET_CFG: next_req.cmd = GET_CFG;
				// keep polling until the conversion is done.
				GET_CFG: next_req.cmd = i_rdata.cfg.os ? SET_PTR_CONV : GET_CFG;
				SET_PTR_CONV: next_req.cmd = GET_CONV;
				default: next_req = cfg_request(last_sample ? next_ch : r_ch);
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			r_state <= S_IDLE;
			r_req <= '0;
			r_ch <= 2'd0;
			r_count <= '0;
			o_start <= 1'b0;
			o_sample_stb <= 1'b0;
		end
		else begin
			o_start <= 1'b0;
			o_sample_stb <= 1'b0;
			case (r_state)
				S_IDLE: r_state <= S_KICK;
				S_KICK: begin
					r_req <= cfg_request(r_ch);
					o_start <= 1'b1;
					r_state <= S_WAIT;
				end
				default: begin
					if (i_end) begin
						r_req <= next_req;
						o_start <= 1'b1;
						if (conv_ok) begin
							o_sample_stb <= 1'b1;
							r_count <= r_count + 1'b1;
							if (last_sample)
								r_ch <= next_ch;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (conv_ok) begin
			o_sample.ch <= r_ch;
			o_sample.code <= i_rdata.conv.code;
		end
	end

endmodule

`default_nettype wire

// File: hw/channel_averager.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_scan_cfg.svh"

module channel_averager (
	input	wire			clk,
	input	wire			rst_n,
	input	wire			i_sample_stb,
	input	wire	[11:0]	i_code,
	output	logic			o_mean_stb,
	output	logic	[11:0]	o_mean
);
	localparam int SUM_W = 12 + `ADC_AVG_LOG2;

	logic [SUM_W-1:0]			r_sum;
	logic [SUM_W-1:0]			sum_next;
	logic [`ADC_AVG_LOG2-1:0]	r_cnt;
	logic						last;

	assign sum_next = r_sum + SUM_W'(i_code);
	assign last = i_sample_stb && (r_cnt == '1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			r_sum <= '0;
			r_cnt <= '0;
			o_mean_stb <= 1'b0;
		end
		else begin
			o_mean_stb <= last;
			if (i_sample_stb) begin
				r_cnt <= r_cnt + 1'b1;
				r_sum <= last ? '0 : sum_next;
			end
		end
	end

	// floor of the mean.
	always_ff @(posedge clk) begin
		if (last)
			o_mean <= sum_next[SUM_W-1:`ADC_AVG_LOG2];
	end

endmodule

`default_nettype wire

// File: hw/i2c_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_scan_cfg.svh"

module i2c_master (
	input	wire					clk,
	input	wire					rst_n,
	input	wire i2c_pkg::i2c_req_t	i_req,
	input	wire					i_start,
	output	logic					o_end,
	output	logic					o_error,
	output	adc_pkg::adc_word_u		o_rdata,
	output	logic					o_scl,
	inout	wire					io_sda
);
	import i2c_pkg::*;

	localparam int QW = $clog2(`I2C_QUARTER_CLKS);

	typedef enum logic [2:0] {
		ST_IDLE, ST_START, ST_WBIT, ST_WACK, ST_RBIT, ST_RACK, ST_STOP
	} state_e;

	state_e			r_state;
	logic [QW-1:0]	r_qcnt;
	logic [1:0]		r_phase;
	logic [2:0]		r_bit;
	logic [1:0]		r_byte;
	logic			r_nack;
	i2c_cmd_e		r_cmd;
	logic [15:0]	r_wdata;
	logic [7:0]		r_tx;
	logic [15:0]	r_rx;
	logic			r_scl;
	logic			r_sda;
	logic			tick;
	logic			bit_end;
	logic			is_read;
	logic			sda_in;
	logic [1:0]		last_wbyte;
	logic [7:0]		next_tx;
	logic			scl_c;
	logic			sda_c;

	assign sda_in = io_sda;
	assign io_sda = r_sda ? 1'bz : 1'b0;
	assign o_scl = r_scl;
	assign o_rdata = r_rx;

	assign is_read = (r_cmd == GET_CFG) || (r_cmd == GET_CONV);
	assign tick = (r_state != ST_IDLE) && (r_qcnt == QW'(`I2C_QUARTER_CLKS - 1));
	assign bit_end = tick && (r_phase == 2'd3);
	// index of the last byte written before a stop or a read.
	assign last_wbyte = (r_cmd == SET_CFG) ? 2'd3 : (r_cmd == SET_PTR_CONV) ? 2'd1 : 2'd0;

	// byte that follows byte r_byte on a write.
	always_comb begin
		case (r_byte)
			2'd0: next_tx = (r_cmd == SET_CFG) ? 8'h01 : 8'h00;
			2'd1: next_tx = r_wdata[15:8];
			default: next_tx = r_wdata[7:0];
		endcase
	end

	// scl is high in quarters 1 and 2 of a bit, sda only moves while scl is low.
	always_comb begin
		scl_c = 1'b1;
		sda_c = 1'b1;
		case (r_state)
			ST_START: begin
				scl_c = (r_phase != 2'd3);
				sda_c = (r_phase < 2'd2);
			end
			ST_WBIT: begin
				scl_c = r_phase[0] ^ r_phase[1];
				sda_c = r_tx[7];
			end
			ST_WACK, ST_RBIT: begin
				scl_c = r_phase[0] ^ r_phase[1];
			end
			ST_RACK: begin
				// ack the first read byte, nack the second.
				scl_c = r_phase[0] ^ r_phase[1];
				sda_c = (r_byte == 2'd1);
			end
			ST_STOP: begin
				scl_c = (r_phase != 2'd0);
				sda_c = r_phase[1];
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			r_state <= ST_IDLE;
			r_qcnt <= '0;
			r_phase <= 2'd0;
			r_bit <= 3'd0;
			r_byte <= 2'd0;
			r_nack <= 1'b0;
			r_cmd <= SET_CFG;
			r_scl <= 1'b1;
			r_sda <= 1'b1;
			o_end <= 1'b0;
			o_error <= 1'b0;
		end
		else begin
			r_scl <= scl_c;
			r_sda <= sda_c;
			o_end <= 1'b0;
			o_error <= 1'b0;
			if (r_state == ST_IDLE) begin
				r_qcnt <= '0;
				r_phase <= 2'd0;
				if (i_start) begin
					r_state <= ST_START;
					r_cmd <= i_req.cmd;
					r_nack <= 1'b0;
				end
			end
			else begin
				r_qcnt <= tick ? '0 : r_qcnt + 1'b1;
				if (tick)
					r_phase <= r_phase + 2'd1;
				if (tick && r_phase == 2'd2 && r_state == ST_WACK)
					r_nack <= sda_in;
				if (bit_end) begin
					case (r_state)
						ST_START: begin
							r_state <= ST_WBIT;
							r_bit <= 3'd0;
							r_byte <= 2'd0;
						end
						ST_WBIT, ST_RBIT: begin
							// r_bit wraps back to 0 after the eighth bit.
							r_bit <= r_bit + 3'd1;
							if (r_bit == 3'd7)
								r_state <= (r_state == ST_WBIT) ? ST_WACK : ST_RACK;
						end
						ST_WACK: begin
							if (r_nack)
								r_state <= ST_STOP;
							else if (r_byte == last_wbyte) begin
								r_state <= is_read ? ST_RBIT : ST_STOP;
								r_byte <= 2'd0;
							end
							else begin
								r_state <= ST_WBIT;
								r_byte <= r_byte + 2'd1;
							end
						end
						ST_RACK: begin
							if (r_byte == 2'd1)
								r_state <= ST_STOP;
							else begin
								r_byte <= 2'd1;
								r_state <= ST_RBIT;
							end
						end
						default: begin
							r_state <= ST_IDLE;
							o_end <= 1'b1;
							o_error <= r_nack;
						end
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (r_state == ST_IDLE && i_start)
			r_wdata <= i_req.wdata;
		if (bit_end && r_state == ST_START)
			r_tx <= {`ADC_I2C_ADDR, is_read};
		else if (bit_end && r_state == ST_WBIT)
			r_tx <= {r_tx[6:0], 1'b0};
		else if (bit_end && r_state == ST_WACK)
			r_tx <= next_tx;
		if (tick && r_phase == 2'd2 && r_state == ST_RBIT)
			r_rx <= {r_rx[14:0], sda_in};
	end

endmodule

`default_nettype wire

// File: hw/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

	// register transactions the master knows.
	// SET_CFG writes pointer 1 and two data bytes, SET_PTR_CONV writes pointer 0 only.
	typedef enum logic [1:0] {
		SET_CFG			= 2'd0,
		GET_CFG			= 2'd1,
		SET_PTR_CONV	= 2'd2,
		GET_CONV		= 2'd3
	} i2c_cmd_e;

	// one request per start strobe.
	// wdata is only sent by SET_CFG.
	typedef struct packed {
		i2c_cmd_e		cmd;
		logic [15:0]	wdata;
	} i2c_req_t;

endpackage

`default_nettype wire

// File: hw/result_publisher.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_scan_cfg.svh"

module result_publisher (
	input	wire						clk,
	input	wire						rst_n,
	input	wire [`ADC_NUM_CH-1:0]		i_mean_stb,
	input	wire adc_pkg::adc_results_t	i_means,
	output	adc_pkg::adc_results_t		o_results,
	output	logic						o_valid
);
	import adc_pkg::*;

	logic [`ADC_NUM_CH-1:0]	r_seen;
	logic [`ADC_NUM_CH-1:0]	seen_next;
	adc_results_t			r_held;
	adc_results_t			merged;

	// newest mean per channel, this cycle's arrivals included.
	always_comb begin
		for (int i = 0; i < `ADC_NUM_CH; i++)
			merged[i] = i_mean_stb[i] ? i_means[i] : r_held[i];
	end

	assign seen_next = r_seen | i_mean_stb;

	always_ff @(posedge clk) begin
		r_held <= merged;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			r_seen <= '0;
			o_valid <= 1'b0;
			o_results <= '0;
		end
		else begin
			o_valid <= 1'b0;
			if (&seen_next) begin
				r_seen <= '0;
				o_valid <= 1'b1;
				o_results <= merged;
			end
			else
				r_seen <= seen_next;
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the adc scanner testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_scan \
	-f compile.f --Mdir obj_dir -o sim_adc_scan > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_adc_scan > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with errors" sim.log; then
	exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

// File: tests/adc_scan_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module adc_scan_asserts (
	input	wire	clk,
	input	wire	rst_n,
	input	wire	i_start,
	input	wire	i_busy,
	input	wire	i_end,
	input	wire	i_error,
	input	wire	i_scl,
	input	wire	i_sda,
	input	wire	i_sda_edge_ok
);

	a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
		i_busy |-> !i_start) else $error("start while the master is busy");

	a_end_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		i_end |=> !i_end) else $error("end longer than one cycle");

	a_error_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		i_error |=> !i_error) else $error("error longer than one cycle");

	// sda only moves under a high scl for start and stop.
	a_sda_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(i_scl && $past(i_scl) && (i_sda !== $past(i_sda))) |->
		(i_sda_edge_ok || $past(i_sda_edge_ok))) else $error("sda moved while scl high");

endmodule

bind i2c_master adc_scan_asserts u_asserts (
	.clk			(clk),
	.rst_n			(rst_n),
	.i_start		(i_start),
	.i_busy			(r_state != ST_IDLE),
	.i_end			(o_end),
	.i_error		(o_error),
	.i_scl			(o_scl),
	.i_sda			(io_sda),
	.i_sda_edge_ok	(r_state == ST_START || r_state == ST_STOP)
);

`default_nettype wire

// File: tests/tb_adc_scan.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_scan_cfg.svh"

module tb_adc_scan;
	import adc_pkg::*;

	localparam int NUM_CASES = 5;
	// generous bound on one sweep, in clk cycles.
	localparam int TIMEOUT = (`ADC_NUM_CH << `ADC_AVG_LOG2) * 400 * 4 * `I2C_QUARTER_CLKS;

	typedef struct packed {
		adc_results_t	base;
		logic			alt;
		logic [3:0]		busy_polls;
		logic [7:0]		nack_pos;
	} case_t;

	logic			clk;
	logic			rst_n;
	wire			sda;
	logic			scl;
	adc_results_t	results;
	logic			valid;
	logic			error;
	logic			m_load;
	adc_results_t	m_base;
	logic			m_alt;
	logic [3:0]		m_busy;
	logic [7:0]		m_nack;
	int				order_errs;
	int				cfg_errs;
	case_t			cases [NUM_CASES];
	int				errors;
	int				checks;
	int				row_errors;
	int				err_pulses;
	logic			nonzero_seen;

	pullup (sda);

	adc_scan_top UUT (
		.clk		(clk),
		.rst_n		(rst_n),
		.o_scl		(scl),
		.io_sda		(sda),
		.o_results	(results),
		.o_valid	(valid),
		.o_error	(error)
	);

	tla2024_model u_adc (
		.clk			(clk),
		.i_scl			(scl),
		.io_sda			(sda),
		.i_load			(m_load),
		.i_base			(m_base),
		.i_alt			(m_alt),
		.i_busy_polls	(m_busy),
		.i_nack_pos		(m_nack),
		.o_order_errs	(order_errs),
		.o_cfg_errs		(cfg_errs)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			row_errors++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic load_case(input case_t c);
		m_base = c.base;
		m_alt = c.alt;
		m_busy = c.busy_polls;
		m_nack = c.nack_pos;
		m_load = 1'b1;
		@(negedge clk);
		m_load = 1'b0;
	endtask

	task automatic wait_valid(output logic ok);
		int cyc;
		ok = 1'b0;
		err_pulses = 0;
		nonzero_seen = 1'b0;
		for (cyc = 0; cyc < TIMEOUT && !ok; cyc++) begin
			@(negedge clk);
			if (error)
				err_pulses++;
			if (valid)
				ok = 1'b1;
			else if (results != '0)
				nonzero_seen = 1'b1;
		end
	endtask

	initial begin
		logic	ok;
		int		i;
		int		ch;
		errors = 0;
		checks = 0;
		rst_n = 1'b0;
		m_load = 1'b0;
		m_base = '0;
		m_alt = 1'b0;
		m_busy = 4'd0;
		m_nack = 8'd0;
		// base codes with channel 0 in the low bits, alternate, busy polls, nack position.
		cases[0] = {48'habc789456123, 1'b0, 4'd0, 8'd0};
		cases[1] = {48'h0002227fe010, 1'b1, 4'd0, 8'd0};
		cases[2] = {48'h555001800fff, 1'b0, 4'd3, 8'd0};
		cases[3] = {48'h3210fedcba98, 1'b0, 4'd1, 8'd5};
		cases[4] = {48'hffd0017777aa, 1'b1, 4'd2, 8'd9};
		@(negedge clk);
		load_case(cases[0]);
		repeat (6) @(negedge clk);
		rst_n = 1'b1;
		for (i = 0; i < NUM_CASES; i++) begin
			row_errors = 0;
			if (i > 0)
				load_case(cases[i]);
			wait_valid(ok);
			if (!ok) begin
				errors++;
				$display("case %0d: no o_valid within %0d cycles", i, TIMEOUT);
				break;
			end
			for (ch = 0; ch < `ADC_NUM_CH; ch++)
				check($sformatf("o_results[%0d]", ch), {20'd0, results[ch]},
					{20'd0, cases[i].base[ch] + 12'(cases[i].alt)});
			check("o_error pulses", err_pulses, {31'd0, cases[i].nack_pos != 8'd0});
			if (i == 0)
				check("o_results before first o_valid", {31'd0, nonzero_seen}, 32'd0);
			@(negedge clk);
			check("o_valid after its pulse", {31'd0, valid}, 32'd0);
			check("mux order errors", order_errs, 32'd0);
			check("config field errors", cfg_errs, 32'd0);
			$display("case %0d: %s, %0d errors", i, (row_errors == 0) ? "ok" : "failed",
				row_errors);
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/tla2024_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_scan_cfg.svh"

module tla2024_model (
	input	wire						clk,
	input	wire						i_scl,
	inout	wire						io_sda,
	input	wire						i_load,
	input	wire adc_pkg::adc_results_t	i_base,
	input	wire						i_alt,
	input	wire [3:0]					i_busy_polls,
	input	wire [7:0]					i_nack_pos,
	output	int							o_order_errs,
	output	int							o_cfg_errs
);
	import adc_pkg::*;

	logic			prev_scl = 1'b1;
	logic			prev_sda = 1'b1;
	logic			drive_low = 1'b0;
	logic			active = 1'b0;
	logic			rd = 1'b0;
	logic			ptr = 1'b0;
	int				bitn = 0;
	int				byten = 0;
	int				addr_count = 0;
	int				busy_left = 0;
	logic [7:0]		shreg = 8'h00;
	logic [7:0]		hi_byte = 8'h00;
	logic [15:0]	tx = 16'h0000;
	logic [15:0]	cfg = 16'h8583;
	logic [1:0]		conv_ch = 2'd0;
	logic [1:0]		last_ch = 2'd0;
	logic [3:0]		toggle = 4'h0;
	logic			start_c;
	logic			stop_c;
	adc_cfg_reg_t	wcfg;

	initial o_order_errs = 0;
	initial o_cfg_errs = 0;

	assign io_sda = drive_low ? 1'b0 : 1'bz;
	assign start_c = i_scl && prev_scl && prev_sda && !io_sda;
	assign stop_c = i_scl && prev_scl && !prev_sda && io_sda;
	assign wcfg = {hi_byte, shreg};

	// bus edges are seen on the system clock, sda is driven only after scl falls.
	always @(posedge clk) begin
		prev_scl <= i_scl;
		prev_sda <= io_sda;
		if (start_c) begin
			active <= 1'b1;
			bitn <= -1;
			byten <= 0;
			rd <= 1'b0;
			drive_low <= 1'b0;
		end
		else if (stop_c) begin
			active <= 1'b0;
			drive_low <= 1'b0;
		end
		else if (active && i_scl && !prev_scl) begin
			if (bitn >= 0 && bitn < 8)
				shreg <= {shreg[6:0], io_sda};
		end
		else if (active && !i_scl && prev_scl) begin
			if (bitn == 7) begin
				bitn <= 8;
				if (rd && byten != 0)
					drive_low <= 1'b0;
				else if (byten == 0) begin
					addr_count <= addr_count + 1;
					if (shreg[7:1] != `ADC_I2C_ADDR || addr_count + 1 == int'(i_nack_pos)) begin
						// nack, then stay off the bus until the next start.
						active <= 1'b0;
						drive_low <= 1'b0;
					end
					else begin
						drive_low <= 1'b1;
						rd <= shreg[0];
						if (shreg[0] && ptr) begin
							tx <= {busy_left == 0, cfg[14:0]};
							if (busy_left != 0)
								busy_left <= busy_left - 1;
						end
						else if (shreg[0]) begin
							// a read before the conversion is done gets no result.
							if (busy_left != 0)
								tx <= 16'h0000;
							else begin
								tx <= {i_base[conv_ch] +
									((i_alt && toggle[conv_ch]) ? 12'd2 : 12'd0), 4'h0};
								toggle[conv_ch] <= !toggle[conv_ch];
							end
						end
					end
				end
				else if (byten == 1) begin
					ptr <= shreg[0];
					drive_low <= 1'b1;
				end
				else if (byten == 2) begin
					hi_byte <= shreg;
					drive_low <= 1'b1;
				end
				else begin
					drive_low <= 1'b1;
					if (ptr) begin
						cfg <= wcfg;
						if (wcfg.os) begin
							busy_left <= int'(i_busy_polls);
							conv_ch <= wcfg.mux[1:0];
							// channels must advance one at a time in order.
							if (!wcfg.mux[2] || (wcfg.mux[1:0] != last_ch &&
									wcfg.mux[1:0] != last_ch + 2'd1))
								o_order_errs <= o_order_errs + 1;
							last_ch <= wcfg.mux[1:0];
							// gain, rate and single-shot mode are fixed.
							if (wcfg.pga != `ADC_PGA_BITS || wcfg.dr != `ADC_DR_BITS ||
									!wcfg.mode)
								o_cfg_errs <= o_cfg_errs + 1;
						end
					end
				end
			end
			else if (bitn == 8) begin
				bitn <= 0;
				byten <= byten + 1;
				if (rd && byten == 0)
					drive_low <= !tx[15];
				else if (rd && byten == 1)
					drive_low <= !tx[7];
				else
					drive_low <= 1'b0;
			end
			else begin
				bitn <= bitn + 1;
				if (rd && byten != 0 && bitn >= 0)
					drive_low <= !tx[(byten == 1 ? 15 : 7) - (bitn + 1)];
			end
		end
		if (i_load) begin
			addr_count <= 0;
			toggle <= 4'h0;
		end
	end

endmodule

`default_nettype wire
